// ==== source/ip_tx_params.svh ====
`ifndef IP_TX_PARAMS_SVH
`define IP_TX_PARAMS_SVH

// payload bytes one source buffer can hold
// the length field in frame_desc_t is sized from this
`define IP_TX_FIFO_DEPTH 64

// time to live for every outgoing datagram
`define IP_TX_TTL 8'd64

// protocol field values
`define IP_TX_PROTO_ICMP 8'd1
`define IP_TX_PROTO_TCP  8'd6

// fixed header size, no options
`define IP_TX_HDR_LEN 20

`endif

// ==== source/ip_tx_pkg.sv ====
`include "ip_tx_params.svh"

package ip_tx_pkg;

	// width of a payload length, 0 up to the full buffer
	localparam int LEN_W = $clog2(`IP_TX_FIFO_DEPTH + 1);

	typedef logic [31:0] ipv4_addr_t;

	// one byte on a source input or on the output stream
	typedef struct packed {
		logic       v;    // single-cycle strobe
		logic       last; // final byte of the frame
		logic [7:0] d;
	} byte_strb_t;

	// top level output, byte plus start of frame
	typedef struct packed {
		byte_strb_t strb;
		logic       sof;
	} out_byte_t;

	// one buffered frame waiting for transmission
	typedef struct packed {
		ipv4_addr_t       dst;
		logic [7:0]       proto;
		logic [LEN_W-1:0] len;   // payload bytes, never 0 when pending
	} frame_desc_t;

	// source index, also the bit position in pending/pop/done vectors
	typedef enum logic {
		SRC_ICMP = 1'b0,
		SRC_TCP  = 1'b1
	} tx_src_t;

	typedef enum logic [1:0] {
		ARB_IDLE    = 2'd0,
		ARB_HDR     = 2'd1, // 20 header bytes
		ARB_PAYLOAD = 2'd2,
		ARB_GAP     = 2'd3  // one idle cycle between frames
	} arb_state_t;

endpackage

// ==== source/payload_fifo.sv ====
`timescale 1ns/1ps
`include "ip_tx_params.svh"

module payload_fifo (
	input  logic                   clk,
	input  logic                   rst_n,
	input  ip_tx_pkg::byte_strb_t  in,
	input  ip_tx_pkg::ipv4_addr_t  dst,
	input  logic [7:0]             proto,
	input  logic                   pop,
	output logic [7:0]             dout,
	output logic                   pending,
	output ip_tx_pkg::frame_desc_t desc,
	output logic                   overflow
);
	import ip_tx_pkg::*;

	localparam int AW = $clog2(`IP_TX_FIFO_DEPTH);

	logic [7:0]       mem [`IP_TX_FIFO_DEPTH];
	logic [LEN_W-1:0] wr_cnt; // bytes written for the frame being built
	logic [LEN_W-1:0] rd_cnt; // bytes already popped
	logic             full;
	logic             push_ok;
	logic             push_drop;
	logic             close;
	logic             last_pop;

	assign full = (wr_cnt == LEN_W'(`IP_TX_FIFO_DEPTH));

	// a finished frame blocks further writes until it is sent
	assign push_ok   = in.v && !pending && !full;
	assign push_drop = in.v && (pending || full);

	// last closes the frame even if its own byte was dropped
	assign close = in.v && in.last && !pending && (push_ok || wr_cnt != '0);

	assign last_pop = pop && (rd_cnt == desc.len - 1'b1);

	always_ff @(posedge clk) begin
		if (push_ok)
			mem[wr_cnt[AW-1:0]] <= in.d;
	end

	// byte is on dout the cycle after its pop
	always_ff @(posedge clk) begin
		if (pop)
			dout <= mem[rd_cnt[AW-1:0]];
	end

	always_ff @(posedge clk) begin
		if (close) begin
			desc.dst   <= dst;
			desc.proto <= proto;
			desc.len   <= push_ok ? wr_cnt + 1'b1 : wr_cnt;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_cnt   <= '0;
			rd_cnt   <= '0;
			pending  <= 1'b0;
			overflow <= 1'b0;
		end else begin
			if (last_pop) begin // frame fully read, rewind
				wr_cnt  <= '0;
				rd_cnt  <= '0;
				pending <= 1'b0;
			end else begin
				if (push_ok)
					wr_cnt <= wr_cnt + 1'b1;
				if (pop)
					rd_cnt <= rd_cnt + 1'b1;
				if (close)
					pending <= 1'b1;
			end
			if (push_drop)
				overflow <= 1'b1; // sticky until reset
		end
	end

	// the arbiter may only read a buffer holding a complete frame
	pop_needs_frame: assert property (@(posedge clk) disable iff (!rst_n)
		pop |-> pending);

endmodule

// ==== source/tx_arbiter.sv ====
`timescale 1ns/1ps

module tx_arbiter (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [1:0]             pending,
	input  ip_tx_pkg::frame_desc_t desc_icmp,
	input  ip_tx_pkg::frame_desc_t desc_tcp,
	input  logic                   hdr_end,
	input  logic                   frame_end,
	output logic [1:0]             pop,
	output logic                   cnt_start,
	output logic                   cnt_step,
	output ip_tx_pkg::frame_desc_t sel_desc,
	output logic [15:0]            pkt_id,
	output ip_tx_pkg::arb_state_t  tx_state,
	output logic [1:0]             done
);
	import ip_tx_pkg::*;

	arb_state_t state;
	arb_state_t state_nxt;
	tx_src_t    last_src; // source being served, or last one served
	tx_src_t    pick;
	logic       grant;
	logic       pop_en;

	// new frame can be taken from idle or straight out of the gap cycle
	assign grant = (state == ARB_IDLE || state == ARB_GAP) && (pending != 2'b00);

	always_comb begin
		if (pending == 2'b11)
			pick = (last_src == SRC_ICMP) ? SRC_TCP : SRC_ICMP; // round robin
		else if (pending[1])
			pick = SRC_TCP;
		else
			pick = SRC_ICMP;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			ARB_IDLE,
			ARB_GAP:     state_nxt = grant ? ARB_HDR : ARB_IDLE;
			ARB_HDR:     if (hdr_end) state_nxt = ARB_PAYLOAD;
			ARB_PAYLOAD: if (frame_end) state_nxt = ARB_GAP;
			default:     state_nxt = ARB_IDLE;
		endcase
	end

	// pop runs one cycle ahead of the byte it feeds
	assign pop_en = (state == ARB_HDR && hdr_end) || (state == ARB_PAYLOAD && !frame_end);
	assign pop    = !pop_en ? 2'b00 : (last_src == SRC_TCP) ? 2'b10 : 2'b01;

	assign cnt_start = grant;
	assign cnt_step  = (state == ARB_HDR) || (state == ARB_PAYLOAD && !frame_end);
	assign tx_state  = state;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= ARB_IDLE;
			last_src <= SRC_TCP; // so ICMP wins the first tie
			sel_desc <= '0;
			pkt_id   <= '0;
			done     <= '0;
		end else begin
			state <= state_nxt;
			done  <= '0;
			if (grant) begin
				last_src <= pick;
				sel_desc <= (pick == SRC_TCP) ? desc_tcp : desc_icmp;
			end
			// registered, lines up with the registered last byte on tx
			if (state == ARB_PAYLOAD && frame_end) begin
				pkt_id <= pkt_id + 16'd1;
				done   <= (last_src == SRC_TCP) ? 2'b10 : 2'b01;
			end
		end
	end

	// only one buffer read at a time, and only one holding a frame
	pop_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(pop) && (pop == 2'b00 || (pop & pending) != 2'b00));

endmodule

// ==== source/frame_counter.sv ====
`timescale 1ns/1ps
`include "ip_tx_params.svh"

module frame_counter (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       start,
	input  logic       step,
	input  logic [6:0] payload_len,
	output logic [6:0] pos,
	output logic       hdr_end,
	output logic       frame_end
);

	logic [6:0] last_pos; // index of the final frame byte

	assign last_pos = 7'(`IP_TX_HDR_LEN - 1) + payload_len;

	assign hdr_end   = (pos == 7'(`IP_TX_HDR_LEN - 1));
	assign frame_end = (pos == last_pos);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pos <= '0;
		else if (start)
			pos <= '0;
		else if (step)
			pos <= pos + 7'd1;
	end

	// arbiter must stop stepping once the last byte is reached
	pos_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
		pos <= last_pos);

endmodule

// ==== source/ipv4_hdr_gen.sv ====
`timescale 1ns/1ps
`include "ip_tx_params.svh"

module ipv4_hdr_gen (
	input  ip_tx_pkg::frame_desc_t desc,
	input  ip_tx_pkg::ipv4_addr_t  src_ip,
	input  logic [15:0]            pkt_id,
	input  logic [6:0]             pos,
	output logic [7:0]             hdr_byte
);

	logic [0:9][15:0]                words; // header words, checksum slot zero
	logic [0:`IP_TX_HDR_LEN-1][7:0] hdr;   // bytes in network order
	logic [19:0]                     sum;
	logic [16:0]                     fold;
	logic [15:0]                     csum;

	always_comb begin
		words[0] = 16'h4500;                                 // version 4, ihl 5, tos 0
		words[1] = 16'(`IP_TX_HDR_LEN) + 16'(desc.len);     // total length
		words[2] = pkt_id;
		words[3] = 16'h4000;                                 // DF set, offset 0
		words[4] = {`IP_TX_TTL, desc.proto};
		words[5] = 16'h0000;
		words[6] = src_ip[31:16];
		words[7] = src_ip[15:0];
		words[8] = desc.dst[31:16];
		words[9] = desc.dst[15:0];
	end

	// ones' complement sum, 20 bits hold ten words without loss
	always_comb begin
		sum = '0;
		for (int i = 0; i < 10; i++)
			sum = sum + 20'(words[i]);
		// two folds are enough, the second cannot carry again
		fold = 17'(sum[15:0]) + 17'(sum[19:16]);
		csum = ~(fold[15:0] + 16'(fold[16]));
	end

	assign hdr = {
		words[0],
		words[1],
		words[2],
		words[3],
		words[4],
		csum,
		words[6],
		words[7],
		words[8],
		words[9]
	};

	always_comb begin
		if (pos < 7'(`IP_TX_HDR_LEN))
			hdr_byte = hdr[pos[4:0]];
		else
			hdr_byte = 8'h00; // past the header, not used by the mux
	end

endmodule

// ==== source/ip_tx_top.sv ====
`timescale 1ns/1ps
`include "ip_tx_params.svh"

module ip_tx_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  ip_tx_pkg::byte_strb_t icmp_in,
	input  ip_tx_pkg::byte_strb_t tcp_in,
	input  ip_tx_pkg::ipv4_addr_t icmp_dst,
	input  ip_tx_pkg::ipv4_addr_t tcp_dst,
	input  ip_tx_pkg::ipv4_addr_t dev_ip,
	output ip_tx_pkg::out_byte_t  tx,
	output logic                  icmp_done,
	output logic                  tcp_done,
	output logic [1:0]            overflow
);
	import ip_tx_pkg::*;

	frame_desc_t desc_icmp;
	frame_desc_t desc_tcp;
	frame_desc_t sel_desc;
	logic [7:0]  dout_icmp;
	logic [7:0]  dout_tcp;
	logic [7:0]  hdr_byte;
	logic [1:0]  pending;
	logic [1:0]  pop;
	logic        pop_q;     // current dout byte came from the tcp buffer
	logic [1:0]  done;
	logic        cnt_start;
	logic        cnt_step;
	logic        hdr_end;
	logic        frame_end;
	logic [6:0]  pos;
	logic [15:0] pkt_id;
	arb_state_t  tx_state;

	payload_fifo icmp_fifo_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.in       (icmp_in),
		.dst      (icmp_dst),
		.proto    (`IP_TX_PROTO_ICMP),
		.pop      (pop[0]),
		.dout     (dout_icmp),
		.pending  (pending[0]),
		.desc     (desc_icmp),
		.overflow (overflow[0])
	);

	payload_fifo tcp_fifo_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.in       (tcp_in),
		.dst      (tcp_dst),
		.proto    (`IP_TX_PROTO_TCP),
		.pop      (pop[1]),
		.dout     (dout_tcp),
		.pending  (pending[1]),
		.desc     (desc_tcp),
		.overflow (overflow[1])
	);

	tx_arbiter arbiter_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.pending   (pending),
		.desc_icmp (desc_icmp),
		.desc_tcp  (desc_tcp),
		.hdr_end   (hdr_end),
		.frame_end (frame_end),
		.pop       (pop),
		.cnt_start (cnt_start),
		.cnt_step  (cnt_step),
		.sel_desc  (sel_desc),
		.pkt_id    (pkt_id),
		.tx_state  (tx_state),
		.done      (done)
	);

	frame_counter counter_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (cnt_start),
		.step        (cnt_step),
		.payload_len (sel_desc.len),
		.pos         (pos),
		.hdr_end     (hdr_end),
		.frame_end   (frame_end)
	);

	ipv4_hdr_gen hdr_gen_inst (
		.desc     (sel_desc),
		.src_ip   (dev_ip),
		.pkt_id   (pkt_id),
		.pos      (pos),
		.hdr_byte (hdr_byte)
	);

	assign icmp_done = done[0];
	assign tcp_done  = done[1];

	// output register, one cycle behind the arbiter state
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx    <= '0;
			pop_q <= '0;
		end else begin
			pop_q <= pop[1];
			tx    <= '0;
			case (tx_state)
				ARB_HDR: begin
					tx.strb.v <= 1'b1;
					tx.strb.d <= hdr_byte;
					tx.sof    <= (pos == 7'd0);
				end
				ARB_PAYLOAD: begin
					tx.strb.v    <= 1'b1;
					tx.strb.d    <= pop_q ? dout_tcp : dout_icmp;
					tx.strb.last <= frame_end;
				end
				default: ; // idle and gap leave tx low
			endcase
		end
	end

endmodule

// ==== tests/tb_ip_tx.sv ====
`timescale 1ns/1ps
`include "ip_tx_params.svh"

module tb_ip_tx;
	import ip_tx_pkg::*;

	localparam int NUM_ROWS = 11;
	localparam logic [31:0] DEV_IP = 32'hc0a8_0a64;

	// one row of the frame table
	typedef struct packed {
		tx_src_t    src;
		ipv4_addr_t dst;
		logic [6:0] len;    // bytes pushed, above the buffer depth overflows
		logic       paired; // last byte together with the next row
		logic       order;  // 0 when this row goes out first of its pair
	} frame_row_t;

	logic       clk;
	logic       rst_n;
	byte_strb_t icmp_in;
	byte_strb_t tcp_in;
	ipv4_addr_t icmp_dst;
	ipv4_addr_t tcp_dst;
	ipv4_addr_t dev_ip;
	out_byte_t  tx;
	logic       icmp_done;
	logic       tcp_done;
	logic [1:0] overflow;

	frame_row_t rows [NUM_ROWS];
	logic [7:0] pay [2][65];
	logic [15:0] lfsr = 16'd72;
	logic [15:0] next_id = 16'd0;
	logic [1:0]  ovf_exp = 2'b00;

	// expected output, filled in serving order
	logic [7:0] exp_bytes [$];
	int         exp_len [$];
	tx_src_t    exp_src [$];
	bit         exp_chk [$];

	int cyc = 0;
	int limit = 0;
	int strobe_cyc = 0;
	int done_cnt = 0;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	// monitor state
	bit         in_frame = 0;
	bit         have_prev = 0;
	int         idx = 0;
	int         cur_len = 0;
	tx_src_t    cur_src = SRC_ICMP;
	bit         cur_chk = 0;
	int         prev_end = 0;
	int         frame_no = 0;
	logic [7:0] exp_b;
	bit         end_now;
	tx_src_t    end_src;

	ip_tx_top DUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.icmp_in   (icmp_in),
		.tcp_in    (tcp_in),
		.icmp_dst  (icmp_dst),
		.tcp_dst   (tcp_dst),
		.dev_ip    (dev_ip),
		.tx        (tx),
		.icmp_done (icmp_done),
		.tcp_done  (tcp_done),
		.overflow  (overflow)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (limit != 0 && cyc >= limit) begin
			$display("timeout: run passed the limit of %0d cycles", limit);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// 16 bit fibonacci lfsr, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic string src_name(input tx_src_t s);
		return (s == SRC_TCP) ? "tcp" : "icmp";
	endfunction

	// reference header, checksum over ten big endian words
	function automatic logic [159:0] ref_header(input logic [15:0] total, input logic [15:0] id,
			input logic [7:0] proto, input ipv4_addr_t src, input ipv4_addr_t dst);
		logic [159:0] h;
		logic [31:0]  acc;
		h = {8'h45, 8'h00, total, id, 16'h4000, `IP_TX_TTL, proto, 16'h0000, src, dst};
		acc = 32'd0;
		for (int w = 0; w < 10; w++)
			acc = acc + {16'h0000, h[159 - 16 * w -: 16]};
		while (acc[31:16] != 16'h0000)
			acc = {16'h0000, acc[15:0]} + {16'h0000, acc[31:16]};
		h[79:64] = ~acc[15:0]; // bytes 10 and 11
		return h;
	endfunction

	task automatic gen_payload(input int slot, input int len);
		logic [7:0] b;
		b = 8'h00;
		for (int k = 0; k < len; k++) begin
			for (int j = 0; j < 8; j++) begin
				lfsr = lfsr_next(lfsr);
				b = {b[6:0], lfsr[0]};
			end
			pay[slot][k] = b;
		end
	endtask

	task automatic queue_frame(input frame_row_t r, input int slot, input bit chk);
		logic [159:0] h;
		logic [7:0]   proto;
		int           n;
		n = (int'(r.len) > `IP_TX_FIFO_DEPTH) ? `IP_TX_FIFO_DEPTH : int'(r.len);
		proto = (r.src == SRC_TCP) ? `IP_TX_PROTO_TCP : `IP_TX_PROTO_ICMP;
		h = ref_header(16'(`IP_TX_HDR_LEN + n), next_id, proto, DEV_IP, r.dst);
		for (int k = 0; k < `IP_TX_HDR_LEN; k++)
			exp_bytes.push_back(h[159 - 8 * k -: 8]);
		for (int k = 0; k < n; k++)
			exp_bytes.push_back(pay[slot][k]);
		exp_len.push_back(`IP_TX_HDR_LEN + n);
		exp_src.push_back(r.src);
		exp_chk.push_back(chk);
		next_id = next_id + 16'd1;
	endtask

	// byte k of an n cycle burst, payload aligned to end on the last cycle
	task automatic drive_row(input frame_row_t r, input int slot, input int k, input int n);
		byte_strb_t s;
		int         first;
		first = n - int'(r.len);
		s = '0;
		if (k >= first) begin
			s.v = 1'b1;
			s.d = pay[slot][k - first];
			s.last = (k == n - 1);
		end
		if (r.src == SRC_TCP) begin
			tcp_in = s;
			tcp_dst = r.dst;
		end else begin
			icmp_in = s;
			icmp_dst = r.dst;
		end
	endtask

	task automatic report_test(input string name, input int err0);
		tests_run++;
		if (errors == err0)
			$display("test %0d %s: ok", tests_run, name);
		else begin
			tests_failed++;
			$display("test %0d %s: FAILED, %0d errors", tests_run, name, errors - err0);
		end
	endtask

	task automatic run_group(input int i, input bit pair);
		frame_row_t a;
		frame_row_t b;
		int         n;
		int         target;
		int         err0;
		string      name;
		err0 = errors;
		a = rows[i];
		b = '0;
		if (pair)
			b = rows[i + 1];
		gen_payload(0, int'(a.len));
		if (pair)
			gen_payload(1, int'(b.len));
		if (!pair)
			queue_frame(a, 0, 1'b1);
		else if (a.order == 1'b0) begin
			queue_frame(a, 0, 1'b1);
			queue_frame(b, 1, 1'b0); // waits behind the first, gap only
		end else begin
			queue_frame(b, 1, 1'b1);
			queue_frame(a, 0, 1'b0);
		end
		target = done_cnt + (pair ? 2 : 1);
		n = (pair && b.len > a.len) ? int'(b.len) : int'(a.len);
		for (int k = 0; k < n; k++) begin
			@(negedge clk);
			icmp_in = '0;
			tcp_in = '0;
			drive_row(a, 0, k, n);
			if (pair)
				drive_row(b, 1, k, n);
			if (k == n - 1)
				strobe_cyc = cyc;
		end
		@(negedge clk);
		icmp_in = '0;
		tcp_in = '0;
		while (done_cnt < target)
			@(posedge clk);
		@(negedge clk);
		if (int'(a.len) > `IP_TX_FIFO_DEPTH)
			ovf_exp[a.src] = 1'b1;
		if (pair && int'(b.len) > `IP_TX_FIFO_DEPTH)
			ovf_exp[b.src] = 1'b1;
		assert (overflow == ovf_exp) else begin
			$display("Mismatch overflow: got %h expected %h", overflow, ovf_exp);
			errors++;
		end
		if (pair)
			name = $sformatf("pair %s len %0d with %s len %0d", src_name(a.src), a.len,
				src_name(b.src), b.len);
		else
			name = $sformatf("%s len %0d", src_name(a.src), a.len);
		report_test(name, err0);
	endtask

	// output monitor, sampled away from the rising edge
	always @(negedge clk) begin
		if (rst_n) begin
			end_now = 1'b0;
			end_src = SRC_ICMP;
			if (tx.strb.v && tx.sof) begin
				assert (!in_frame) else begin
					$display("frame %0d cut short after %0d bytes by a new frame", frame_no, idx);
					errors++;
				end
				if (in_frame) begin
					repeat (cur_len - idx) void'(exp_bytes.pop_front());
					in_frame = 0;
					frame_no++;
				end
				assert (exp_len.size() != 0) else begin
					$display("frame on tx at cycle %0d that no source sent", cyc);
					errors++;
				end
				if (exp_len.size() != 0) begin
					cur_len = exp_len.pop_front();
					cur_src = exp_src.pop_front();
					cur_chk = exp_chk.pop_front();
					in_frame = 1;
					idx = 0;
					if (have_prev)
						assert (cyc - prev_end >= 2) else begin
							$display("frame %0d started with no idle cycle after the last one", frame_no);
							errors++;
						end
					// last byte taken at the next rising edge, sof two edges later
					if (cur_chk)
						assert (cyc == strobe_cyc + 3) else begin
							$display("frame %0d started at cycle %0d instead of cycle %0d",
								frame_no, cyc, strobe_cyc + 3);
							errors++;
						end
				end
			end
			if (tx.strb.v && in_frame) begin
				exp_b = exp_bytes.pop_front();
				assert (tx.strb.d == exp_b) else begin
					$display("Mismatch tx.strb.d frame %0d byte %0d: got %h expected %h",
						frame_no, idx, tx.strb.d, exp_b);
					errors++;
				end
				assert (tx.strb.last == (idx == cur_len - 1)) else begin
					$display("Mismatch tx.strb.last frame %0d byte %0d: got %h expected %h",
						frame_no, idx, tx.strb.last, idx == cur_len - 1);
					errors++;
				end
				if (idx == cur_len - 1) begin
					end_now = 1'b1;
					end_src = cur_src;
					in_frame = 0;
					have_prev = 1;
					prev_end = cyc;
					frame_no++;
				end
				idx++;
			end else if (tx.strb.v) begin
				$display("byte on tx at cycle %0d outside of any frame", cyc);
				errors++;
			end else if (in_frame) begin
				$display("tx.v dropped in frame %0d after %0d of %0d bytes", frame_no, idx, cur_len);
				errors++;
				repeat (cur_len - idx) void'(exp_bytes.pop_front());
				in_frame = 0;
				frame_no++;
			end
			assert (icmp_done == (end_now && end_src == SRC_ICMP)) else begin
				$display("Mismatch icmp_done at cycle %0d: got %h expected %h", cyc, icmp_done,
					end_now && end_src == SRC_ICMP);
				errors++;
			end
			assert (tcp_done == (end_now && end_src == SRC_TCP)) else begin
				$display("Mismatch tcp_done at cycle %0d: got %h expected %h", cyc, tcp_done,
					end_now && end_src == SRC_TCP);
				errors++;
			end
			if (icmp_done)
				done_cnt++;
			if (tcp_done)
				done_cnt++;
		end
	end

	initial begin
		int i;
		int err0;
		rows[0]  = '{SRC_ICMP, 32'hc0a8_0a01, 7'd16, 1'b0, 1'b0};
		rows[1]  = '{SRC_TCP,  32'hc0a8_0a02, 7'd1,  1'b0, 1'b0};
		rows[2]  = '{SRC_TCP,  32'h0a00_0005, 7'd64, 1'b0, 1'b0};
		rows[3]  = '{SRC_ICMP, 32'hac10_ff01, 7'd33, 1'b0, 1'b0};
		rows[4]  = '{SRC_ICMP, 32'hc0a8_0103, 7'd8,  1'b1, 1'b1}; // icmp served last, tcp wins
		rows[5]  = '{SRC_TCP,  32'hc0a8_0104, 7'd20, 1'b0, 1'b0};
		rows[6]  = '{SRC_TCP,  32'h0808_0808, 7'd2,  1'b0, 1'b0};
		rows[7]  = '{SRC_ICMP, 32'hc0a8_0a09, 7'd12, 1'b1, 1'b0}; // tcp served last, icmp wins
		rows[8]  = '{SRC_TCP,  32'hc0a8_0a0a, 7'd40, 1'b0, 1'b1};
		rows[9]  = '{SRC_ICMP, 32'hc0a8_0a0b, 7'd65, 1'b0, 1'b0}; // one byte too many
		rows[10] = '{SRC_TCP,  32'hc0a8_0a0c, 7'd7,  1'b0, 1'b0};

		// push time, header and payload, plus slack per row
		limit = 8 + 4 + 20;
		for (int r = 0; r < NUM_ROWS; r++)
			limit += 2 * int'(rows[r].len) + `IP_TX_HDR_LEN + 10;

		rst_n = 1'b0;
		icmp_in = '0;
		tcp_in = '0;
		icmp_dst = '0;
		tcp_dst = '0;
		dev_ip = DEV_IP;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		err0 = errors;
		repeat (4) begin
			@(negedge clk);
			assert (tx.strb.v == 1'b0) else begin
				$display("Mismatch tx.strb.v after reset: got %h expected 0", tx.strb.v);
				errors++;
			end
			assert ({icmp_done, tcp_done} == 2'b00) else begin
				$display("Mismatch done after reset: got %h expected 0", {icmp_done, tcp_done});
				errors++;
			end
			assert (overflow == 2'b00) else begin
				$display("Mismatch overflow after reset: got %h expected 0", overflow);
				errors++;
			end
		end
		report_test("reset state", err0);

		i = 0;
		while (i < NUM_ROWS) begin
			if (rows[i].paired) begin
				run_group(i, 1'b1);
				i += 2;
			end else begin
				run_group(i, 1'b0);
				i += 1;
			end
		end

		assert (exp_len.size() == 0) else begin
			$display("%0d expected frames never appeared on tx", exp_len.size());
			errors++;
		end
		$display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+source
source/ip_tx_pkg.sv
source/payload_fifo.sv
source/tx_arbiter.sv
source/frame_counter.sv
source/ipv4_hdr_gen.sv
source/ip_tx_top.sv
tests/tb_ip_tx.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_ip_tx
FILELIST := build.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(wildcard source/*.sv source/*.svh tests/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qF -- "*** TEST PASSED ***" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
